//--- Makefile
# Verilator build for the rv64i execute core

VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= tb_exec_core
RTL_TOP   ?= exec_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

RTL_FILES = $(shell grep '^verilog/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
verilog/rv_pkg.sv
verilog/key_lookup.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/exec_core.sv
test/tb_exec_core.sv

//--- test/tb_exec_core.sv
// directed testbench for exec_core with a register and pc reference model
`timescale 1ns/100ps

module tb_exec_core;

  localparam int max_cycles = 4000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        inst_valid;
  logic        inst_ready;
  logic [31:0] inst;
  logic        ret_valid;
  logic        ret_ready;
  logic [63:0] ret_pc;
  logic [63:0] ret_next_pc;
  logic [4:0]  ret_rd;
  logic        ret_wen;
  logic [63:0] ret_wdata;
  logic        ret_unsup;
  logic        ret_halt;

  logic [63:0] model_regs [32];
  logic [63:0] model_pc;
  logic [63:0] exp_pc, exp_next, exp_wdata;
  logic [4:0]  exp_rd;
  logic        exp_wen, exp_unsup, exp_halt;
  int          errors = 0;
  int          tests = 0;
  int          cycles = 0;

  exec_core dut0 (
    .clk (clk), .rst_n (rst_n), .inst_valid (inst_valid), .inst_ready (inst_ready),
    .inst (inst), .ret_valid (ret_valid), .ret_ready (ret_ready), .ret_pc (ret_pc),
    .ret_next_pc (ret_next_pc), .ret_rd (ret_rd), .ret_wen (ret_wen),
    .ret_wdata (ret_wdata), .ret_unsup (ret_unsup), .ret_halt (ret_halt)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::opc_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], rv_pkg::opc_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::opc_jal};
  endfunction

  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic [63:0] rand_imm12();
    logic [31:0] r;
    r = $urandom;
    return {{52{r[11]}}, r[11:0]};
  endfunction

  // builds the word and the expected record and updates the model
  task automatic predict(input string name, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [63:0] imm,
                         output logic [31:0] word);
    logic [63:0] a, b, pc4;
    a = model_regs[rs1];
    b = model_regs[rs2];
    pc4 = model_pc + 64'd4;
    exp_pc = model_pc;
    exp_next = pc4;
    exp_rd = rd;
    exp_wen = 1'b1;
    exp_wdata = 64'd0;
    exp_unsup = 1'b0;
    exp_halt = 1'b0;
    word = 32'd0;
    case (name)
      "lui": begin
        word = {imm[31:12], rd, rv_pkg::opc_lui};
        exp_wdata = imm;
      end
      "auipc": begin
        word = {imm[31:12], rd, rv_pkg::opc_auipc};
        exp_wdata = model_pc + imm;
      end
      "jal": begin
        word = enc_j(imm[20:0], rd);
        exp_wdata = pc4;
        exp_next = model_pc + imm;
      end
      "jalr": begin
        word = enc_i(imm[11:0], rs1, 3'b000, rd, rv_pkg::opc_jalr);
        exp_wdata = pc4;
        exp_next = (a + imm) & ~64'd1;
      end
      "bne": begin
        word = enc_b(imm[12:0], rs2, rs1);
        exp_wen = 1'b0;
        if (a != b) exp_next = model_pc + imm;
      end
      "addi": begin
        word = enc_i(imm[11:0], rs1, 3'b000, rd, rv_pkg::opc_op_imm);
        exp_wdata = a + imm;
      end
      "sltiu": begin
        word = enc_i(imm[11:0], rs1, 3'b011, rd, rv_pkg::opc_op_imm);
        exp_wdata = {63'b0, a < imm};
      end
      "xori": begin
        word = enc_i(imm[11:0], rs1, 3'b100, rd, rv_pkg::opc_op_imm);
        exp_wdata = a ^ imm;
      end
      "andi": begin
        word = enc_i(imm[11:0], rs1, 3'b111, rd, rv_pkg::opc_op_imm);
        exp_wdata = a & imm;
      end
      "addiw": begin
        word = enc_i(imm[11:0], rs1, 3'b000, rd, rv_pkg::opc_op_imm_32);
        exp_wdata = sext32(a[31:0] + imm[31:0]);
      end
      "slli": begin
        word = enc_i({6'b000000, imm[5:0]}, rs1, 3'b001, rd, rv_pkg::opc_op_imm);
        exp_wdata = a << imm[5:0];
      end
      "srli": begin
        word = enc_i({6'b000000, imm[5:0]}, rs1, 3'b101, rd, rv_pkg::opc_op_imm);
        exp_wdata = a >> imm[5:0];
      end
      "srai": begin
        word = enc_i({6'b010000, imm[5:0]}, rs1, 3'b101, rd, rv_pkg::opc_op_imm);
        exp_wdata = $signed(a) >>> imm[5:0];
      end
      "add": begin
        word = enc_r(7'h00, rs2, rs1, 3'b000, rd, rv_pkg::opc_op);
        exp_wdata = a + b;
      end
      "sub": begin
        word = enc_r(7'h20, rs2, rs1, 3'b000, rd, rv_pkg::opc_op);
        exp_wdata = a - b;
      end
      "sltu": begin
        word = enc_r(7'h00, rs2, rs1, 3'b011, rd, rv_pkg::opc_op);
        exp_wdata = {63'b0, a < b};
      end
      "or": begin
        word = enc_r(7'h00, rs2, rs1, 3'b110, rd, rv_pkg::opc_op);
        exp_wdata = a | b;
      end
      "and": begin
        word = enc_r(7'h00, rs2, rs1, 3'b111, rd, rv_pkg::opc_op);
        exp_wdata = a & b;
      end
      "addw": begin
        word = enc_r(7'h00, rs2, rs1, 3'b000, rd, rv_pkg::opc_op_32);
        exp_wdata = sext32(a[31:0] + b[31:0]);
      end
      "sllw": begin
        word = enc_r(7'h00, rs2, rs1, 3'b001, rd, rv_pkg::opc_op_32);
        exp_wdata = sext32(a[31:0] << b[4:0]);
      end
      "lw": word = enc_i(imm[11:0], rs1, 3'b010, rd, rv_pkg::opc_load);
      "lbu": word = enc_i(imm[11:0], rs1, 3'b100, rd, rv_pkg::opc_load);
      "ld": word = enc_i(imm[11:0], rs1, 3'b011, rd, rv_pkg::opc_load);
      "sb": word = enc_s(imm[11:0], rs2, rs1, 3'b000);
      "sh": word = enc_s(imm[11:0], rs2, rs1, 3'b001);
      "sd": word = enc_s(imm[11:0], rs2, rs1, 3'b011);
      "unknown": word = enc_i(imm[11:0], rs1, 3'b000, rd, 7'b1111111);
      "ebreak": word = 32'h0010_0073;
      default: begin
        $display("model has no rule for %s", name);
        errors++;
      end
    endcase
    if (name inside {"lw", "lbu", "ld", "sb", "sh", "sd", "unknown"}) exp_unsup = 1'b1;
    if (exp_unsup || name == "ebreak") exp_wen = 1'b0;
    if (name == "ebreak") exp_halt = 1'b1;
    if (exp_wen && rd != 5'd0) model_regs[rd] = exp_wdata;
    model_pc = exp_next;
  endtask

  task automatic check_val(input string sig, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", sig, got, exp);
      errors++;
    end
  endtask

  task automatic send_inst(input logic [31:0] word);
    @(posedge clk);
    inst_valid <= 1'b1;
    inst <= word;
    @(negedge clk);
    while (!inst_ready) @(negedge clk);
    @(posedge clk);
    inst_valid <= 1'b0;
  endtask

  // fields are compared at the falling edge where they are stable
  task automatic expect_ret();
    @(negedge clk);
    while (!ret_valid) @(negedge clk);
    check_val("ret_pc", ret_pc, exp_pc);
    check_val("ret_next_pc", ret_next_pc, exp_next);
    check_val("ret_wen", {63'b0, ret_wen}, {63'b0, exp_wen});
    check_val("ret_unsup", {63'b0, ret_unsup}, {63'b0, exp_unsup});
    check_val("ret_halt", {63'b0, ret_halt}, {63'b0, exp_halt});
    if (exp_wen) begin
      check_val("ret_rd", {59'b0, ret_rd}, {59'b0, exp_rd});
      check_val("ret_wdata", ret_wdata, exp_wdata);
    end
    @(posedge clk); // record drains here
  endtask

  task automatic run(input string name, input logic [4:0] rd, input logic [4:0] rs1,
                     input logic [4:0] rs2, input logic [63:0] imm);
    logic [31:0] word;
    predict(name, rd, rs1, rs2, imm, word);
    send_inst(word);
    expect_ret();
  endtask

  task automatic apply_reset();
    rst_n <= 1'b0;
    inst_valid <= 1'b0;
    ret_ready <= 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < 32; i++) model_regs[i] = 64'd0;
    model_pc = rv_pkg::reset_pc;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests++;
    $display("test %s: %0d errors", name, errors - errs_before);
  endtask

  task automatic set_reg64(input logic [4:0] rd);
    logic [31:0] r;
    r = $urandom;
    run("lui", rd, 5'd0, 5'd0, sext32({r[31:12], 12'h000}));
    run("addi", rd, rd, 5'd0, rand_imm12());
    run("slli", rd, rd, 5'd0, 64'd32);
    run("lui", 5'd31, 5'd0, 5'd0, sext32({20'($urandom), 12'h000}));
    run("or", rd, rd, 5'd31, 64'd0);
  endtask

  task automatic test_imm_arith();
    int e0;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      run("lui", 5'(i + 1), 5'd0, 5'd0, sext32({20'($urandom), 12'h000}));
      run("addi", 5'(i + 9), 5'(i + 1), 5'd0, rand_imm12());
      run("sltiu", 5'(i + 17), 5'(i + 9), 5'd0, rand_imm12());
      run("xori", 5'(i + 1), 5'(i + 9), 5'd0, rand_imm12());
      run("andi", 5'(i + 9), 5'(i + 1), 5'd0, rand_imm12());
      run("auipc", 5'(i + 17), 5'd0, 5'd0, sext32({20'($urandom), 12'h000}));
    end
    run("addi", 5'd0, 5'd3, 5'd0, 64'hffff_ffff_ffff_fffb); // x0 write is dropped
    run("add", 5'd4, 5'd0, 5'd0, 64'd0);
    finish_test("imm_arith", e0);
  endtask

  task automatic test_reg_ops();
    string ops [8] = '{"add", "sub", "sltu", "or", "and", "slli", "srli", "srai"};
    int e0;
    e0 = errors;
    for (int r = 1; r <= 6; r++) set_reg64(5'(r));
    for (int i = 0; i < 24; i++) begin
      run(ops[i % 8], 5'($urandom_range(7, 9)), 5'($urandom_range(1, 9)),
          5'($urandom_range(1, 9)), 64'($urandom % 64));
    end
    run("lui", 5'd10, 5'd0, 5'd0, 64'hffff_ffff_8000_0000);
    run("addiw", 5'd10, 5'd10, 5'd0, 64'hffff_ffff_ffff_ffff); // 0x7fffffff
    run("addiw", 5'd11, 5'd10, 5'd0, 64'd1);
    run("addw", 5'd12, 5'd10, 5'd10, 64'd0);
    run("addi", 5'd14, 5'd0, 5'd0, 64'd33);
    run("sllw", 5'd13, 5'd10, 5'd14, 64'd0);
    run("addw", 5'd13, 5'd1, 5'd2, 64'd0);
    finish_test("reg_ops", e0);
  endtask

  task automatic test_control();
    int e0;
    e0 = errors;
    run("addi", 5'd20, 5'd0, 5'd0, 64'd5);
    run("bne", 5'd0, 5'd20, 5'd0, 64'd16);
    run("bne", 5'd0, 5'd20, 5'd20, 64'd16);
    run("bne", 5'd0, 5'd20, 5'd0, 64'hffff_ffff_ffff_fff0);
    run("jal", 5'd1, 5'd0, 5'd0, 64'hffff_ffff_ffff_fff8);
    run("jal", 5'd2, 5'd0, 5'd0, 64'd2048);
    run("auipc", 5'd15, 5'd0, 5'd0, 64'd4096);
    run("jalr", 5'd3, 5'd15, 5'd0, 64'd13);
    run("jalr", 5'd0, 5'd15, 5'd0, 64'hffff_ffff_ffff_fff1);
    run("addi", 5'd21, 5'd3, 5'd0, 64'd0);
    finish_test("control", e0);
  endtask

  task automatic test_unsup();
    string ops [7] = '{"lw", "lbu", "ld", "sb", "sh", "sd", "unknown"};
    int e0;
    e0 = errors;
    foreach (ops[i]) run(ops[i], 5'd1, 5'd2, 5'd3, rand_imm12());
    run("or", 5'd22, 5'd1, 5'd0, 64'd0); // register survived
    finish_test("unsup", e0);
  endtask

  task automatic test_backpressure();
    logic [31:0] wa, wb;
    logic [63:0] a_pc, a_wdata;
    int e0;
    e0 = errors;
    predict("addi", 5'd5, 5'd0, 5'd0, 64'd123, wa);
    a_pc = exp_pc;
    a_wdata = exp_wdata;
    @(posedge clk);
    ret_ready <= 1'b0;
    send_inst(wa);
    @(posedge clk);
    inst_valid <= 1'b1;
    predict("add", 5'd6, 5'd5, 5'd5, 64'd0, wb);
    inst <= wb;
    repeat (4) begin
      @(negedge clk);
      if (inst_ready) begin
        $display("inst_ready stayed high while the retire slot was blocked");
        errors++;
      end
      check_val("ret_valid", {63'b0, ret_valid}, 64'd1);
      check_val("ret_pc", ret_pc, a_pc);
      check_val("ret_wdata", ret_wdata, a_wdata);
    end
    @(posedge clk);
    ret_ready <= 1'b1;
    @(negedge clk);
    while (!inst_ready) @(negedge clk);
    @(posedge clk);
    inst_valid <= 1'b0;
    expect_ret();
    finish_test("backpressure", e0);
  endtask

  task automatic test_ebreak();
    logic [31:0] w;
    int e0;
    e0 = errors;
    run("ebreak", 5'd0, 5'd0, 5'd0, 64'd0);
    predict("addi", 5'd7, 5'd0, 5'd0, 64'd1, w);
    @(posedge clk);
    inst_valid <= 1'b1;
    inst <= w;
    repeat (6) begin
      @(negedge clk);
      if (inst_ready || ret_valid) begin
        $display("core accepted an instruction after ebreak");
        errors++;
      end
    end
    @(posedge clk);
    apply_reset();
    @(negedge clk);
    if (!inst_ready || ret_valid) begin
      $display("handshake state after reset is wrong");
      errors++;
    end
    run("addi", 5'd7, 5'd0, 5'd0, 64'd1);
    finish_test("ebreak", e0);
  endtask

  initial begin
    void'($urandom(32'h7c24_21aa));
    rst_n = 1'b0;
    inst_valid = 1'b0;
    inst = 32'd0;
    ret_ready = 1'b1;
    apply_reset();
    test_imm_arith();
    test_reg_ops();
    test_control();
    test_unsup();
    test_backpressure();
    test_ebreak();
    $display("%0d tests, %0d errors, %0d cycles", tests, errors, cycles);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/alu.sv
// execute unit: write-back value, write enable and next pc for one decoded operation
`timescale 1ns/100ps

module alu (
  input  logic [rv_pkg::op_w-1:0] op,
  input  logic [rv_pkg::xlen-1:0] pc,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  input  logic [63:0]             imm_i,
  input  logic [63:0]             imm_u,
  input  logic [63:0]             imm_j,
  input  logic [63:0]             imm_b,
  input  logic [5:0]              shamt,
  output logic [rv_pkg::xlen-1:0] wdata,
  output logic                    wen,
  output logic [rv_pkg::xlen-1:0] next_pc
);

  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] sum_ri; // rs1 + imm_i, shared by addi/addiw/jalr
  logic [rv_pkg::xlen-1:0] sum_rr;
  logic [31:0]             sllw_w;

  function automatic logic [rv_pkg::xlen-1:0] sext_w(input logic [31:0] v);
    return {{(rv_pkg::xlen-32){v[31]}}, v};
  endfunction

  assign pc_plus4 = pc + 64'd4;
  assign sum_ri   = rs1_data + imm_i;
  assign sum_rr   = rs1_data + rs2_data;
  assign sllw_w   = rs1_data[31:0] << rs2_data[4:0];

  always_comb begin
    wdata   = '0;
    wen     = 1'b1;
    next_pc = pc_plus4;
    case (op)
      rv_pkg::op_lui:   wdata = imm_u;
      rv_pkg::op_auipc: wdata = pc + imm_u;
      rv_pkg::op_jal: begin
        wdata   = pc_plus4; // link
        next_pc = pc + imm_j;
      end
      rv_pkg::op_jalr: begin
        wdata   = pc_plus4;
        next_pc = {sum_ri[rv_pkg::xlen-1:1], 1'b0}; // bit 0 cleared
      end
      rv_pkg::op_bne: begin
        wen = 1'b0;
        if (rs1_data != rs2_data) begin
          next_pc = pc + imm_b;
        end
      end
      rv_pkg::op_addi:  wdata = sum_ri;
      rv_pkg::op_sltiu: wdata = {63'b0, rs1_data < imm_i};
      rv_pkg::op_xori:  wdata = rs1_data ^ imm_i;
      rv_pkg::op_andi:  wdata = rs1_data & imm_i;
      rv_pkg::op_slli:  wdata = rs1_data << shamt;
      rv_pkg::op_srli:  wdata = rs1_data >> shamt;
      rv_pkg::op_srai:  wdata = $signed(rs1_data) >>> shamt;
      rv_pkg::op_add:   wdata = sum_rr;
      rv_pkg::op_sub:   wdata = rs1_data - rs2_data;
      rv_pkg::op_sltu:  wdata = {63'b0, rs1_data < rs2_data};
      rv_pkg::op_or:    wdata = rs1_data | rs2_data;
      rv_pkg::op_and:   wdata = rs1_data & rs2_data;
      // word ops keep the low 32 bits, sign-extended
      rv_pkg::op_addiw: wdata = sext_w(sum_ri[31:0]);
      rv_pkg::op_addw:  wdata = sext_w(sum_rr[31:0]);
      rv_pkg::op_sllw:  wdata = sext_w(sllw_w);
      default:          wen = 1'b0; // unsupported, memory, ebreak
    endcase
  end

endmodule

//--- verilog/exec_core.sv
// rv64i execute core: pc, instruction and retire handshakes, halt state, retire record
`timescale 1ns/100ps

module exec_core (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    inst_valid,
  output logic                    inst_ready,
  input  logic [31:0]             inst,
  output logic                    ret_valid,
  input  logic                    ret_ready,
  output logic [rv_pkg::xlen-1:0] ret_pc,
  output logic [rv_pkg::xlen-1:0] ret_next_pc,
  output logic [4:0]              ret_rd,
  output logic                    ret_wen,
  output logic [rv_pkg::xlen-1:0] ret_wdata,
  output logic                    ret_unsup,
  output logic                    ret_halt
);

  logic [rv_pkg::xlen-1:0] pc;
  logic                    halted;
  logic                    accept;

  logic [4:0]              dec_rd;
  logic [4:0]              dec_rs1;
  logic [4:0]              dec_rs2;
  logic [5:0]              dec_shamt;
  logic [63:0]             imm_i;
  logic [63:0]             imm_u;
  logic [63:0]             imm_j;
  logic [63:0]             imm_b;
  logic [rv_pkg::op_w-1:0] dec_op;

  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;
  logic [rv_pkg::xlen-1:0] alu_wdata;
  logic [rv_pkg::xlen-1:0] alu_next_pc;
  logic                    alu_wen;
  logic                    is_unsup;

  // stall on halt or a full retire slot that is not draining
  assign inst_ready = !halted && (!ret_valid || ret_ready);
  assign accept     = inst_valid && inst_ready;

  assign is_unsup = dec_op inside {rv_pkg::op_unsup, rv_pkg::op_mem_lw, rv_pkg::op_mem_lbu,
                                   rv_pkg::op_mem_ld, rv_pkg::op_mem_sb, rv_pkg::op_mem_sh,
                                   rv_pkg::op_mem_sd};

  inst_decode u_decode (
    .inst  (inst),
    .rd    (dec_rd),
    .rs1   (dec_rs1),
    .rs2   (dec_rs2),
    .shamt (dec_shamt),
    .imm_i (imm_i),
    .imm_u (imm_u),
    .imm_j (imm_j),
    .imm_b (imm_b),
    .imm_s (),           // stores not executed
    .op    (dec_op)
  );

  reg_file u_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (dec_rs1),
    .raddr2 (dec_rs2),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data),
    .we     (accept && alu_wen),
    .waddr  (dec_rd),
    .wdata  (alu_wdata)
  );

  alu u_alu (
    .op       (dec_op),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm_i    (imm_i),
    .imm_u    (imm_u),
    .imm_j    (imm_j),
    .imm_b    (imm_b),
    .shamt    (dec_shamt),
    .wdata    (alu_wdata),
    .wen      (alu_wen),
    .next_pc  (alu_next_pc)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc        <= rv_pkg::reset_pc;
      halted    <= 1'b0;
      ret_valid <= 1'b0;
    end else if (accept) begin
      pc        <= alu_next_pc;
      ret_valid <= 1'b1;
      if (dec_op == rv_pkg::op_ebreak) begin
        halted <= 1'b1; // sticky until reset
      end
    end else if (ret_ready) begin
      ret_valid <= 1'b0;
    end
  end

  // retire payload, held while ret_valid waits on ret_ready
  always_ff @(posedge clk) begin
    if (accept) begin
      ret_pc      <= pc;
      ret_next_pc <= alu_next_pc;
      ret_rd      <= dec_rd;
      ret_wen     <= alu_wen;
      ret_wdata   <= alu_wdata;
      ret_unsup   <= is_unsup;
      ret_halt    <= (dec_op == rv_pkg::op_ebreak);
    end
  end

endmodule

//--- verilog/inst_decode.sv
// instruction decoder: field split, sign-extended immediates and operation id lookup
`timescale 1ns/100ps

module inst_decode (
  input  logic [31:0]             inst,
  output logic [4:0]              rd,
  output logic [4:0]              rs1,
  output logic [4:0]              rs2,
  output logic [5:0]              shamt,
  output logic [63:0]             imm_i,
  output logic [63:0]             imm_u,
  output logic [63:0]             imm_j,
  output logic [63:0]             imm_b,
  output logic [63:0]             imm_s,
  output logic [rv_pkg::op_w-1:0] op
);

  rv_pkg::rv_inst_u w;

  logic [rv_pkg::op_w-1:0] op_f3;
  logic [rv_pkg::op_w-1:0] op_opc;
  logic [rv_pkg::op_w-1:0] op_r;
  logic [rv_pkg::op_w-1:0] op_sh;

  assign w = inst;

  assign rd    = w.r.rd;
  assign rs1   = w.r.rs1;
  assign rs2   = w.r.rs2;
  assign shamt = {w.r.funct7[0], w.r.rs2}; // rv64 shifts use 6 bits

  assign imm_i = {{52{w.i.imm12[11]}}, w.i.imm12};
  assign imm_u = {{32{w.u.imm20[19]}}, w.u.imm20, 12'b0};
  assign imm_s = {{52{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
  // j and b immediates are scattered, read them off the raw word
  assign imm_j = {{44{w.raw[31]}}, w.raw[19:12], w.raw[20], w.raw[30:21], 1'b0};
  assign imm_b = {{52{w.raw[31]}}, w.raw[7], w.raw[30:25], w.raw[11:8], 1'b0};

  key_lookup #(.nr_key(13), .key_len(10), .data_len(rv_pkg::op_w)) lk_f3 (
    .key ({w.i.funct3, w.i.opcode}),
    .lut ({
      3'b000, rv_pkg::opc_jalr,      rv_pkg::op_jalr,
      3'b001, rv_pkg::opc_branch,    rv_pkg::op_bne,
      3'b010, rv_pkg::opc_load,      rv_pkg::op_mem_lw,
      3'b100, rv_pkg::opc_load,      rv_pkg::op_mem_lbu,
      3'b011, rv_pkg::opc_load,      rv_pkg::op_mem_ld,
      3'b000, rv_pkg::opc_store,     rv_pkg::op_mem_sb,
      3'b001, rv_pkg::opc_store,     rv_pkg::op_mem_sh,
      3'b011, rv_pkg::opc_store,     rv_pkg::op_mem_sd,
      3'b000, rv_pkg::opc_op_imm,    rv_pkg::op_addi,
      3'b011, rv_pkg::opc_op_imm,    rv_pkg::op_sltiu,
      3'b100, rv_pkg::opc_op_imm,    rv_pkg::op_xori,
      3'b111, rv_pkg::opc_op_imm,    rv_pkg::op_andi,
      3'b000, rv_pkg::opc_op_imm_32, rv_pkg::op_addiw
    }),
    .out (op_f3)
  );

  key_lookup #(.nr_key(3), .key_len(7), .data_len(rv_pkg::op_w)) lk_opc (
    .key (w.u.opcode),
    .lut ({
      rv_pkg::opc_lui,   rv_pkg::op_lui,
      rv_pkg::opc_auipc, rv_pkg::op_auipc,
      rv_pkg::opc_jal,   rv_pkg::op_jal
    }),
    .out (op_opc)
  );

  key_lookup #(.nr_key(7), .key_len(17), .data_len(rv_pkg::op_w)) lk_r (
    .key ({w.r.funct7, w.r.funct3, w.r.opcode}),
    .lut ({
      7'b0000000, 3'b000, rv_pkg::opc_op,    rv_pkg::op_add,
      7'b0100000, 3'b000, rv_pkg::opc_op,    rv_pkg::op_sub,
      7'b0000000, 3'b011, rv_pkg::opc_op,    rv_pkg::op_sltu,
      7'b0000000, 3'b110, rv_pkg::opc_op,    rv_pkg::op_or,
      7'b0000000, 3'b111, rv_pkg::opc_op,    rv_pkg::op_and,
      7'b0000000, 3'b000, rv_pkg::opc_op_32, rv_pkg::op_addw,
      7'b0000000, 3'b001, rv_pkg::opc_op_32, rv_pkg::op_sllw
    }),
    .out (op_r)
  );

  // funct6 only, bit 25 belongs to shamt
  key_lookup #(.nr_key(3), .key_len(16), .data_len(rv_pkg::op_w)) lk_sh (
    .key ({w.r.funct7[6:1], w.r.funct3, w.r.opcode}),
    .lut ({
      6'b000000, 3'b001, rv_pkg::opc_op_imm, rv_pkg::op_slli,
      6'b000000, 3'b101, rv_pkg::opc_op_imm, rv_pkg::op_srli,
      6'b010000, 3'b101, rv_pkg::opc_op_imm, rv_pkg::op_srai
    }),
    .out (op_sh)
  );

  // groups are disjoint so at most one lookup is non-zero
  assign op = (w.raw == rv_pkg::ebreak_word) ? rv_pkg::op_ebreak
                                             : (op_f3 | op_opc | op_r | op_sh);

endmodule

//--- verilog/key_lookup.sv
// key/value table lookup returning the data of the matching key, zero otherwise
`timescale 1ns/100ps

module key_lookup #(
  parameter int nr_key   = 2,
  parameter int key_len  = 1,
  parameter int data_len = 1
) (
  input  logic [key_len-1:0]                      key,
  input  logic [nr_key*(key_len+data_len)-1:0]    lut,
  output logic [data_len-1:0]                     out
);

  // each pair is {key, data} with data in the low bits
  always_comb begin
    out = '0;
    for (int i = 0; i < nr_key; i++) begin
      if (lut[i*(key_len+data_len)+data_len +: key_len] == key) begin
        out = lut[i*(key_len+data_len) +: data_len]; // keys are unique
      end
    end
  end

endmodule

//--- verilog/reg_file.sv
// 32 x 64 integer register file, two async reads, one write, x0 hardwired to zero
`timescale 1ns/100ps

module reg_file (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [4:0]              raddr1,
  input  logic [4:0]              raddr2,
  output logic [rv_pkg::xlen-1:0] rdata1,
  output logic [rv_pkg::xlen-1:0] rdata2,
  input  logic                    we,
  input  logic [4:0]              waddr,
  input  logic [rv_pkg::xlen-1:0] wdata
);

  logic [rv_pkg::xlen-1:0] regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata; // x0 writes dropped
    end
  end

  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- verilog/rv_pkg.sv
// rv64i core definitions: widths, reset pc, major opcodes, operation ids, instruction views
package rv_pkg;

  localparam int xlen = 64;
  localparam logic [xlen-1:0] reset_pc = 64'h8000_0000;
  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opc_lui       = 7'b0110111;
  localparam logic [6:0] opc_auipc     = 7'b0010111;
  localparam logic [6:0] opc_jal       = 7'b1101111;
  localparam logic [6:0] opc_jalr      = 7'b1100111;
  localparam logic [6:0] opc_branch    = 7'b1100011;
  localparam logic [6:0] opc_load      = 7'b0000011;
  localparam logic [6:0] opc_store     = 7'b0100011;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_32     = 7'b0111011;
  localparam logic [6:0] opc_system    = 7'b1110011;

  localparam int op_w = 5;

  // operation ids, zero is reserved for no match
  localparam logic [op_w-1:0] op_unsup  = 5'd0;
  localparam logic [op_w-1:0] op_lui    = 5'd1;
  localparam logic [op_w-1:0] op_auipc  = 5'd2;
  localparam logic [op_w-1:0] op_jal    = 5'd3;
  localparam logic [op_w-1:0] op_jalr   = 5'd4;
  localparam logic [op_w-1:0] op_bne    = 5'd5;
  localparam logic [op_w-1:0] op_addi   = 5'd6;
  localparam logic [op_w-1:0] op_sltiu  = 5'd7;
  localparam logic [op_w-1:0] op_xori   = 5'd8;
  localparam logic [op_w-1:0] op_andi   = 5'd9;
  localparam logic [op_w-1:0] op_slli   = 5'd10;
  localparam logic [op_w-1:0] op_srli   = 5'd11;
  localparam logic [op_w-1:0] op_srai   = 5'd12;
  localparam logic [op_w-1:0] op_add    = 5'd13;
  localparam logic [op_w-1:0] op_sub    = 5'd14;
  localparam logic [op_w-1:0] op_sltu   = 5'd15;
  localparam logic [op_w-1:0] op_or     = 5'd16;
  localparam logic [op_w-1:0] op_and    = 5'd17;
  localparam logic [op_w-1:0] op_addiw  = 5'd18;
  localparam logic [op_w-1:0] op_addw   = 5'd19;
  localparam logic [op_w-1:0] op_sllw   = 5'd20;
  localparam logic [op_w-1:0] op_ebreak = 5'd21;
  // memory ops are decoded but retire as unsupported
  localparam logic [op_w-1:0] op_mem_lw  = 5'd22;
  localparam logic [op_w-1:0] op_mem_lbu = 5'd23;
  localparam logic [op_w-1:0] op_mem_ld  = 5'd24;
  localparam logic [op_w-1:0] op_mem_sb  = 5'd25;
  localparam logic [op_w-1:0] op_mem_sh  = 5'd26;
  localparam logic [op_w-1:0] op_mem_sd  = 5'd27;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_t;

  typedef struct packed {
    logic [6:0] imm_hi; // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo; // imm[4:0]
    logic [6:0] opcode;
  } rv_s_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_t;

  typedef union packed {
    rv_r_t       r;
    rv_i_t       i;
    rv_s_t       s;
    rv_u_t       u;
    logic [31:0] raw;
  } rv_inst_u;

endpackage
